/* sources.f */
common/cache_pkg.sv
ways/way_store.sv
source/hit_logic.sv
replace/lru_matrix.sv
replace/victim_select.sv
source/cache_top.sv
test/cache_asserts.sv
test/cache_tb.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cache_tb -f sources.f \
	&& { ./obj_dir/Vcache_tb > sim.log 2>&1 || echo "Some tests failed" >> sim.log; } \
	|| exit 1
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0

/* test/cache_tb.sv */
`timescale 1ns/1ns

module cache_tb;
	import cache_pkg::*;

	// Cycles used by all tests together, reset included
	localparam int test_cycles = 3 + 4 + 9 + 13 + 21 + 2 + 201;

	logic clk;
	logic reset;
	cache_addr_t address;
	logic read_signal;
	logic write_signal;
	logic [block_w-1:0] write_data;
	logic [7:0] write_byte;
	logic read_hit;
	logic write_hit;
	logic [7:0] read_data;
	logic hit;
	logic halt_hit;

	// Reference model: contents of every way and one LRU matrix per set
	logic m_valid [num_sets][num_ways];
	logic [halt_w-1:0] m_halt [num_sets][num_ways];
	logic [tag_w-1:0] m_tag [num_sets][num_ways];
	logic [block_w-1:0] m_data [num_sets][num_ways];
	logic [num_ways-1:0] m_lru [num_sets][num_ways];

	integer seed;
	string cur_test;
	int test_errors;
	int passed;
	int failed;

	cache_top dut0 (
		.clk(clk),
		.reset(reset),
		.address(address),
		.read_signal(read_signal),
		.write_signal(write_signal),
		.write_data(write_data),
		.write_byte(write_byte),
		.read_hit(read_hit),
		.write_hit(write_hit),
		.read_data(read_data),
		.hit(hit),
		.halt_hit(halt_hit)
	);

	always #5 clk = ~clk;

	task automatic check(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("mismatch %s %s expected %0h actual %0h", cur_test, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic report_test();
		if (test_errors == 0)
		begin
			$display("%s: ok", cur_test);
			passed++;
		end
		else
		begin
			$display("%s: %0d errors", cur_test, test_errors);
			failed++;
		end
	endtask

	function automatic cache_addr_t make_addr(input logic [tag_w-1:0] tag,
		input logic [halt_w-1:0] halt, input logic [set_w-1:0] index,
		input logic [offset_w-1:0] offset);
		cache_addr_t a;
		a.tag = tag;
		a.halt_tag = halt;
		a.index = index;
		a.offset = offset;
		return a;
	endfunction

	// A way passes the halt filter when valid with an equal halt tag
	function automatic logic model_lookup(input cache_addr_t a, output way_t way,
		output logic any_halt);
		logic found;
		found = 1'b0;
		way = '0;
		any_halt = 1'b0;
		for (int w = 0; w < num_ways; w++)
		begin
			if (m_valid[a.index][w] && m_halt[a.index][w] == a.halt_tag)
			begin
				any_halt = 1'b1;
				if (m_tag[a.index][w] == a.tag)
				begin
					found = 1'b1;
					way = way_t'(w);
				end
			end
		end
		return found;
	endfunction

	function automatic way_t model_victim(input logic [set_w-1:0] s);
		for (int w = 0; w < num_ways; w++)
		begin
			if (!m_valid[s][w])
			begin
				return way_t'(w);
			end
		end
		for (int w = 0; w < num_ways; w++)
		begin
			if (m_lru[s][w] == '0)
			begin
				return way_t'(w);
			end
		end
		return '0;
	endfunction

	// One cycle of traffic; want_hit below zero leaves the hit to the model alone
	task automatic access(input logic rd, input logic wr, input cache_addr_t a,
		input logic [block_w-1:0] wdata, input logic [7:0] wbyte, input int want_hit);
		logic exp_hit;
		logic exp_halt;
		way_t way;
		logic [7:0] exp_byte;
		@(negedge clk);
		address = a;
		read_signal = rd;
		write_signal = wr;
		write_data = wdata;
		write_byte = wbyte;
		exp_hit = model_lookup(a, way, exp_halt);
		exp_byte = exp_hit ? m_data[a.index][way][{a.offset, 3'b000} +: 8] : 8'h00;
		#1;
		check("hit", 64'(exp_hit), 64'(hit));
		check("halt_hit", 64'(exp_halt), 64'(halt_hit));
		check("read_hit", 64'(exp_hit && rd), 64'(read_hit));
		check("write_hit", 64'(exp_hit && wr && !rd), 64'(write_hit));
		check("read_data", 64'(exp_byte), 64'(read_data));
		if (want_hit >= 0)
		begin
			check("intended hit", 64'(want_hit), 64'(hit));
		end
		@(posedge clk);
		if ((rd || wr) && !exp_hit)
		begin
			way = model_victim(a.index);
			m_valid[a.index][way] = 1'b1;
			m_halt[a.index][way] = a.halt_tag;
			m_tag[a.index][way] = a.tag;
			m_data[a.index][way] = wdata;
		end
		else if (wr && !rd && exp_hit)
		begin
			m_data[a.index][way][{a.offset, 3'b000} +: 8] = wbyte;
		end
		if (rd || wr)
		begin
			m_lru[a.index][way] = '1;
			for (int r = 0; r < num_ways; r++)
			begin
				m_lru[a.index][r][way] = 1'b0;
			end
		end
	endtask

	task automatic after_reset_reads();
		start_test("after_reset");
		for (int i = 0; i < 4; i++)
		begin
			access(1'b1, 1'b0, make_addr(22'(i + 1), 4'(i), 3'(i), 3'(i)), 64'(i), 8'h00, 0);
		end
		report_test();
	endtask

	task automatic fill_then_hit();
		cache_addr_t a;
		start_test("fill_then_hit");
		a = make_addr(22'h100, 4'h5, 3'd2, 3'd0);
		access(1'b1, 1'b0, a, 64'h0123_4567_89ab_cdef, 8'h00, 0);
		for (int o = 0; o < block_bytes; o++)
		begin
			a.offset = 3'(o);
			access(1'b1, 1'b0, a, '0, 8'h00, 1);
		end
		report_test();
	endtask

	task automatic byte_write();
		cache_addr_t a;
		start_test("byte_write");
		a = make_addr(22'h2a, 4'h3, 3'd4, 3'd2);
		// The write miss loads the whole block and write_byte plays no part
		access(1'b0, 1'b1, a, 64'hfedc_ba98_7654_3210, 8'hee, 0);
		access(1'b1, 1'b0, a, '0, 8'h00, 1);
		a.offset = 3'd5;
		access(1'b0, 1'b1, a, '0, 8'h5a, 1);
		// Both strobes high is a read, so 8'h11 must not land
		access(1'b1, 1'b1, a, '0, 8'h11, 1);
		access(1'b0, 1'b0, a, '0, 8'h00, 1);
		check("new byte", 64'h5a, 64'(read_data));
		for (int o = 0; o < block_bytes; o++)
		begin
			a.offset = 3'(o);
			access(1'b1, 1'b0, a, '0, 8'h00, 1);
		end
		report_test();
	endtask

	task automatic replacement();
		start_test("replacement");
		for (int k = 0; k < num_ways; k++)
		begin
			access(1'b1, 1'b0, make_addr(22'h300 + 22'(k), 4'(k), 3'd6, 3'd0), 64'(k), 8'h00, 0);
		end
		for (int k = 0; k < 3; k++)
		begin
			access(1'b1, 1'b0, make_addr(22'h300 + 22'(k), 4'(k), 3'd6, 3'd0), '0, 8'h00, 1);
		end
		// Way 3 is now least recently used and takes the ninth tag
		access(1'b1, 1'b0, make_addr(22'h308, 4'h8, 3'd6, 3'd0), '1, 8'h00, 0);
		for (int k = 0; k < num_ways; k++)
		begin
			access(1'b0, 1'b0, make_addr(22'h300 + 22'(k), 4'(k), 3'd6, 3'd0), '0, 8'h00,
				(k == 3) ? 0 : 1);
		end
		access(1'b0, 1'b0, make_addr(22'h308, 4'h8, 3'd6, 3'd0), '0, 8'h00, 1);
		report_test();
	endtask

	task automatic way_halting();
		start_test("way_halting");
		access(1'b0, 1'b0, make_addr(22'h3ff, 4'h1, 3'd6, 3'd0), '0, 8'h00, 0);
		check("halt match", 64'd1, 64'(halt_hit));
		access(1'b0, 1'b0, make_addr(22'h301, 4'hf, 3'd6, 3'd0), '0, 8'h00, 0);
		check("halt differs", 64'd0, 64'(halt_hit));
		report_test();
	endtask

	// Four tags and four halt tags over four sets force regular evictions
	task automatic random_traffic();
		logic [31:0] r;
		start_test("random_traffic");
		for (int i = 0; i < 200; i++)
		begin
			r = $random(seed);
			access(r[9], r[10], make_addr(22'h3a0 + 22'(r[1:0]), 4'(r[3:2]), 3'(r[5:4]), r[8:6]),
				{$random(seed), $random(seed)}, r[18:11], -1);
		end
		access(1'b0, 1'b0, '0, '0, 8'h00, -1);
		report_test();
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		address = '0;
		read_signal = 1'b0;
		write_signal = 1'b0;
		write_data = '0;
		write_byte = '0;
		seed = 32'h8479;
		passed = 0;
		failed = 0;
		for (int s = 0; s < num_sets; s++)
		begin
			for (int w = 0; w < num_ways; w++)
			begin
				m_valid[s][w] = 1'b0;
				m_lru[s][w] = '0;
			end
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		after_reset_reads();
		fill_then_hit();
		byte_write();
		replacement();
		way_halting();
		random_traffic();
		$display("Tests: %0d passed, %0d failed", passed, failed);
		if (failed == 0)
		begin
			$display("All tests passed");
		end
		else
		begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial
	begin
		#((test_cycles + 100) * 10);
		$display("Timeout: the tests did not finish in time");
		$display("Some tests failed");
		$finish;
	end

endmodule

/* test/cache_asserts.sv */
`timescale 1ns/1ns

module cache_asserts
(
	input logic clk,
	input logic reset,
	input logic read_hit,
	input logic write_hit,
	input logic hit,
	input logic halt_hit
);

	assert property (@(posedge clk) disable iff (reset) read_hit |-> hit)
		else $error("read_hit high without hit");

	// A full tag match can only happen on a way that passed the halt filter
	assert property (@(posedge clk) disable iff (reset) hit |-> halt_hit)
		else $error("hit high without halt_hit");

	assert property (@(posedge clk) disable iff (reset) !(read_hit && write_hit))
		else $error("read_hit and write_hit high together");

	// Valid bits are clear once the first reset edge has passed
	assert property (@(posedge clk)
		reset && $past(reset) |-> !(hit || halt_hit || read_hit || write_hit))
		else $error("hit output high during reset");

endmodule

bind cache_top cache_asserts u_asserts (
	.clk(clk),
	.reset(reset),
	.read_hit(read_hit),
	.write_hit(write_hit),
	.hit(hit),
	.halt_hit(halt_hit)
);

/* source/cache_top.sv */
`timescale 1ns/1ns

module cache_top
	import cache_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  cache_addr_t address,
	input  logic read_signal,
	input  logic write_signal,
	input  logic [block_w-1:0] write_data,
	input  logic [7:0] write_byte,
	output logic read_hit,
	output logic write_hit,
	output logic [7:0] read_data,
	output logic hit,
	output logic halt_hit
);

	way_entry_t entries [num_ways];
	way_mask_t entries_valid;
	way_mask_t hit_mask;
	way_mask_t write_mask;
	way_t hit_way;
	way_t lru_way;
	way_t touch_way;
	logic touch;

	genvar w;
	generate
		for (w = 0; w < num_ways; w++)
		begin : g_way
			// The enabled way fills on a miss and takes one byte on a hit
			way_store u_way (
				.clk(clk),
				.reset(reset),
				.index(address.index),
				.offset(address.offset),
				.write_en(write_mask[w]),
				.fill(!hit_mask[w]),
				.tag(address.tag),
				.halt_tag(address.halt_tag),
				.write_data(write_data),
				.write_byte(write_byte),
				.entry(entries[w])
			);

			assign entries_valid[w] = entries[w].valid;
		end
	endgenerate

	hit_logic u_hit (
		.entries(entries),
		.addr_tag(address.tag),
		.addr_halt(address.halt_tag),
		.offset(address.offset),
		.hit_mask(hit_mask),
		.hit_way(hit_way),
		.hit(hit),
		.halt_hit(halt_hit),
		.read_data(read_data)
	);

	lru_matrix u_lru (
		.clk(clk),
		.reset(reset),
		.index(address.index),
		.touch(touch),
		.touch_way(touch_way),
		.lru_way(lru_way)
	);

	victim_select u_victim (
		.entries_valid(entries_valid),
		.lru_way(lru_way),
		.hit(hit),
		.hit_way(hit_way),
		.read_signal(read_signal),
		.write_signal(write_signal),
		.write_mask(write_mask),
		.touch(touch),
		.touch_way(touch_way)
	);

	// A read takes priority when both strobes are high
	assign read_hit = hit && read_signal;
	assign write_hit = hit && write_signal && !read_signal;

endmodule

/* replace/victim_select.sv */
`timescale 1ns/1ns

module victim_select
	import cache_pkg::*;
(
	input  way_mask_t entries_valid,
	input  way_t lru_way,
	input  logic hit,
	input  way_t hit_way,
	input  logic read_signal,
	input  logic write_signal,
	output way_mask_t write_mask,
	output logic touch,
	output way_t touch_way
);

	way_t invalid_way;
	logic have_invalid;
	way_t victim_way;
	logic read_hit_access;

	// Lowest-numbered empty way in the set
	always_comb
	begin
		have_invalid = 1'b0;
		invalid_way = '0;
		for (int w = 0; w < num_ways; w++)
		begin
			if (!have_invalid && !entries_valid[w])
			begin
				invalid_way = way_t'(w);
				have_invalid = 1'b1;
			end
		end
	end

	assign victim_way = have_invalid ? invalid_way : lru_way;

	// Both strobes high counts as a read
	assign read_hit_access = read_signal && hit;

	assign touch = read_signal || write_signal;
	assign touch_way = hit ? hit_way : victim_way;

	always_comb
	begin
		write_mask = '0;
		if (touch && !read_hit_access)
		begin
			write_mask[touch_way] = 1'b1;
		end
	end

endmodule

/* replace/lru_matrix.sv */
`timescale 1ns/1ns

module lru_matrix
	import cache_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic [set_w-1:0] index,
	input  logic touch,
	input  way_t touch_way,
	output way_t lru_way
);

	// Bit c of row r is set when way r was used after way c
	logic [num_ways-1:0] mat_q [num_sets][num_ways];
	logic [num_ways-1:0] cur_rows [num_ways];
	logic [num_ways-1:0] next_rows [num_ways];
	way_mask_t row_empty;

	always_comb
	begin
		for (int r = 0; r < num_ways; r++)
		begin
			cur_rows[r] = mat_q[index][r];
			row_empty[r] = (cur_rows[r] == '0);
		end
	end

	// Set the touched row, then clear the touched column in every row
	always_comb
	begin
		for (int r = 0; r < num_ways; r++)
		begin
			if (way_t'(r) == touch_way)
			begin
				next_rows[r] = '1;
			end
			else
			begin
				next_rows[r] = cur_rows[r];
			end
			next_rows[r][touch_way] = 1'b0;
		end
	end

	// The lowest way with an empty row is the least recently used
	always_comb
	begin
		logic found;
		found = 1'b0;
		lru_way = '0;
		for (int r = 0; r < num_ways; r++)
		begin
			if (!found && row_empty[r])
			begin
				lru_way = way_t'(r);
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < num_sets; s++)
			begin
				for (int r = 0; r < num_ways; r++)
				begin
					mat_q[s][r] <= '0;
				end
			end
		end
		else if (touch)
		begin
			for (int r = 0; r < num_ways; r++)
			begin
				mat_q[index][r] <= next_rows[r];
			end
		end
	end

endmodule

/* source/hit_logic.sv */
`timescale 1ns/1ns

module hit_logic
	import cache_pkg::*;
(
	input  way_entry_t entries [num_ways],
	input  logic [tag_w-1:0] addr_tag,
	input  logic [halt_w-1:0] addr_halt,
	input  logic [offset_w-1:0] offset,
	output way_mask_t hit_mask,
	output way_t hit_way,
	output logic hit,
	output logic halt_hit,
	output logic [7:0] read_data
);

	// Ways that survive the halt tag filter
	way_mask_t active;
	logic [block_w-1:0] hit_block;

	// An invalid way or one with a different halt tag is halted
	always_comb
	begin
		for (int w = 0; w < num_ways; w++)
		begin
			active[w] = entries[w].valid && (entries[w].halt_tag == addr_halt);
		end
	end

	// Full tag compare only on the active ways
	always_comb
	begin
		for (int w = 0; w < num_ways; w++)
		begin
			hit_mask[w] = active[w] && (entries[w].tag == addr_tag);
		end
	end

	assign halt_hit = |active;
	assign hit = |hit_mask;

	// At most one way can match, so the first set bit is the hit way
	always_comb
	begin
		hit_way = '0;
		for (int w = num_ways - 1; w >= 0; w--)
		begin
			if (hit_mask[w])
			begin
				hit_way = way_t'(w);
			end
		end
	end

	assign hit_block = entries[hit_way].data;

	always_comb
	begin
		if (hit)
		begin
			read_data = hit_block[{offset, 3'b000} +: 8];
		end
		else
		begin
			read_data = '0;
		end
	end

endmodule

/* ways/way_store.sv */
`timescale 1ns/1ns

module way_store
	import cache_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic [set_w-1:0] index,
	input  logic [offset_w-1:0] offset,
	input  logic write_en,
	input  logic fill,
	input  logic [tag_w-1:0] tag,
	input  logic [halt_w-1:0] halt_tag,
	input  logic [block_w-1:0] write_data,
	input  logic [7:0] write_byte,
	output way_entry_t entry
);

	// One entry per set for this way
	logic [num_sets-1:0] valid_q;
	logic [halt_w-1:0] halt_q [num_sets];
	logic [tag_w-1:0] tag_q [num_sets];
	logic [block_w-1:0] data_q [num_sets];

	logic do_fill;
	logic do_byte;

	assign do_fill = write_en && fill;
	assign do_byte = write_en && !fill;

	// Valid bits are the only state that reset touches
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_q <= '0;
		end
		else if (do_fill)
		begin
			valid_q[index] <= 1'b1;
		end
	end

	// Tags change only when the block is replaced
	always_ff @(posedge clk)
	begin
		if (do_fill)
		begin
			halt_q[index] <= halt_tag;
			tag_q[index] <= tag;
		end
	end

	// A fill loads the whole block, a write hit patches one byte
	always_ff @(posedge clk)
	begin
		if (do_fill)
		begin
			data_q[index] <= write_data;
		end
		else if (do_byte)
		begin
			data_q[index][{offset, 3'b000} +: 8] <= write_byte;
		end
	end

	assign entry.valid = valid_q[index];
	assign entry.halt_tag = halt_q[index];
	assign entry.tag = tag_q[index];
	assign entry.data = data_q[index];

endmodule

/* common/cache_pkg.sv */
package cache_pkg;

	// Cache geometry
	localparam int num_ways = 8;
	localparam int num_sets = 8;
	localparam int block_bytes = 8;
	localparam int addr_w = 32;
	localparam int halt_w = 4;

	// Derived widths
	localparam int way_w = $clog2(num_ways);
	localparam int set_w = $clog2(num_sets);
	localparam int offset_w = $clog2(block_bytes);
	localparam int tag_w = addr_w - halt_w - set_w - offset_w;
	localparam int block_w = block_bytes * 8;

	// Way number and one bit per way
	typedef logic [way_w-1:0] way_t;
	typedef logic [num_ways-1:0] way_mask_t;

	// Byte address as seen on the cache port, most significant field first
	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic [halt_w-1:0] halt_tag;
		logic [set_w-1:0] index;
		logic [offset_w-1:0] offset;
	} cache_addr_t;

	// One way's contents at the indexed set
	typedef struct packed {
		logic valid;
		logic [halt_w-1:0] halt_tag;
		logic [tag_w-1:0] tag;
		logic [block_w-1:0] data;
	} way_entry_t;

endpackage
